// ==== Makefile ====
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module aprTb -f compile.f -Mdir obj_dir -o aprSim

run: compile
	./obj_dir/aprSim > $(LOG) 2>&1 || true
	cat $(LOG)
	! grep -q "Test FAILED" $(LOG)
	grep -q "Test OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== compile.f ====
design/aprPkg.sv
design/aprCtlIf.sv
design/aprIoDecode.sv
design/aprConditionFlags.sv
design/aprFmAddress.sv
design/aprReadback.sv
design/aprTop.sv
tests/aprTop_assertions.sv
tests/aprTb.sv

// ==== design/aprConditionFlags.sv ====
`timescale 1ns/1ps
`default_nettype none

module aprConditionFlags (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         sbusErr,
  input  logic                         nxmErr,
  input  logic                         ioPfErr,
  input  logic                         mbParErr,
  input  logic                         cDirParErr,
  input  logic                         sAdrParErr,
  input  logic                         pwrWarn,
  input  logic                         sweepBusy,
  aprCtlIf.flags                       ctl,
  output logic [aprPkg::NumConds-1:0]  flags,
  output logic [aprPkg::NumConds-1:0]  enables,
  output logic [2:0]                   piaLevel,
  output logic                         aprInterrupt
);

  logic sweepBusyQ;
  logic sweepFall;
  logic [aprPkg::NumConds-1:0] events;
  logic [aprPkg::NumConds-1:0] setMask;
  logic [aprPkg::NumConds-1:0] clrMask;
  logic [aprPkg::NumConds-1:0] enMask;
  logic [aprPkg::NumConds-1:0] disMask;
  logic [aprPkg::NumConds-1:0] flagsNext;
  logic [aprPkg::NumConds-1:0] enablesNext;

  // Sweep done fires when the cache sweep stops
  assign sweepFall = sweepBusyQ & ~sweepBusy;

  always_comb begin
    events = '0;
    events[aprPkg::CondSbusErr]    = sbusErr;
    events[aprPkg::CondNxmErr]     = nxmErr;
    events[aprPkg::CondIoPfErr]    = ioPfErr;
    events[aprPkg::CondMbParErr]   = mbParErr;
    events[aprPkg::CondCDirParErr] = cDirParErr;
    events[aprPkg::CondSAdrParErr] = sAdrParErr;
    events[aprPkg::CondPwrFail]    = pwrWarn;
    events[aprPkg::CondSweepDone]  = sweepFall;
  end

  always_comb begin
    setMask = {aprPkg::NumConds{ctl.selSet}} & ctl.condMask;
    clrMask = {aprPkg::NumConds{ctl.selClr}} & ctl.condMask;
    enMask  = {aprPkg::NumConds{ctl.selEn}} & ctl.condMask;
    disMask = {aprPkg::NumConds{ctl.selDis}} & ctl.condMask;
    // Event beats clear
    flagsNext   = events | setMask | (flags & ~clrMask);
    // Disable beats enable
    enablesNext = (enables | enMask) & ~disMask;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      flags      <= '0;
      enables    <= '0;
      piaLevel   <= '0;
      sweepBusyQ <= 1'b0;
    end else begin
      flags      <= flagsNext;
      enables    <= enablesNext;
      sweepBusyQ <= sweepBusy;
      if (ctl.piaLoad) begin
        piaLevel <= ctl.piaLevel;
      end
    end
  end

  assign aprInterrupt = |(flags & enables);

endmodule

`default_nettype wire

// ==== design/aprCtlIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface aprCtlIf #(
  parameter int BlockBits = 3
);
  logic selEn;
  logic selDis;
  logic selClr;
  logic selSet;
  logic [aprPkg::NumConds-1:0] condMask;
  logic piaLoad;
  logic [2:0] piaLevel;
  logic loadBlocks;
  logic [BlockBits-1:0] curBlockIn;
  logic [BlockBits-1:0] prevBlockIn;
  logic dataoLoad;
  logic [3:0] compIn;
  logic readConi;
  logic readDatai;

  modport decoder (
    output selEn, selDis, selClr, selSet, condMask, piaLoad, piaLevel,
           loadBlocks, curBlockIn, prevBlockIn, dataoLoad, compIn,
           readConi, readDatai
  );
  modport flags (input selEn, selDis, selClr, selSet, condMask, piaLoad, piaLevel);
  modport blocks (input loadBlocks, curBlockIn, prevBlockIn);
  modport readback (input readConi, readDatai, dataoLoad, compIn);
endinterface

`default_nettype wire

// ==== design/aprFmAddress.sv ====
`timescale 1ns/1ps
`default_nettype none

module aprFmAddress #(
  parameter int BlockBits = 3
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [3:0]            ac,
  input  logic [3:0]            xr,
  input  logic [3:0]            vmaAdr,
  input  logic [8:0]            magic,
  input  aprPkg::fmSrcT         fmSrc,
  input  logic                  xrPrevious,
  input  logic                  vmaPrevEn,
  input  logic                  loadVmaContext,
  aprCtlIf.blocks               ctl,
  output logic [BlockBits-1:0]  curBlock,
  output logic [BlockBits-1:0]  prevBlock,
  output logic [3:0]            fmAdr,
  output logic [BlockBits-1:0]  fmBlock
);

  logic [3:0] acPlus1;
  logic [3:0] acPlus2;
  logic [3:0] acPlus3;
  logic [3:0] acPlusMagic;
  logic [2:0] magicBlock;
  logic [BlockBits-1:0] xrBlock;
  logic [BlockBits-1:0] vmaBlock;

  // All sums wrap within the 16-word AC file
  always_comb begin
    acPlus1     = ac + 4'd1;
    acPlus2     = ac + 4'd2;
    acPlus3     = ac + 4'd3;
    acPlusMagic = ac + magic[8:5];
    magicBlock  = magic[4:2];
  end

  always_comb begin
    case (fmSrc)
      aprPkg::FmAc:      fmAdr = ac;
      aprPkg::FmAcPlus1: fmAdr = acPlus1;
      aprPkg::FmXr:      fmAdr = xr;
      aprPkg::FmVma:     fmAdr = vmaAdr;
      aprPkg::FmAcPlus2: fmAdr = acPlus2;
      aprPkg::FmAcPlus3: fmAdr = acPlus3;
      aprPkg::FmAcMagic: fmAdr = acPlusMagic;
      default:           fmAdr = magic[8:5];
    endcase
  end

  assign xrBlock = xrPrevious ? prevBlock : curBlock;

  always_comb begin
    case (fmSrc)
      aprPkg::FmXr:    fmBlock = xrBlock;
      aprPkg::FmVma:   fmBlock = vmaBlock;
      aprPkg::FmMagic: fmBlock = magicBlock[BlockBits-1:0];
      default:         fmBlock = curBlock;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      curBlock  <= '0;
      prevBlock <= '0;
      vmaBlock  <= '0;
    end else begin
      if (ctl.loadBlocks) begin
        curBlock  <= ctl.curBlockIn;
        prevBlock <= ctl.prevBlockIn;
      end
      // Context for the next memory reference
      if (loadVmaContext) begin
        vmaBlock <= vmaPrevEn ? prevBlock : curBlock;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/aprIoDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module aprIoDecode #(
  parameter int BlockBits = 3
) (
  input  logic                          ioValid,
  input  aprPkg::ioFuncT                ioFunc,
  input  logic [aprPkg::WordBits-1:0]   ioData,
  aprCtlIf.decoder                      ctl
);

  logic isCono;
  logic isConi;
  logic isDatao;
  logic isDatai;
  logic isLoad;

  always_comb begin
    isCono  = ioValid && (ioFunc == aprPkg::IoCono);
    isConi  = ioValid && (ioFunc == aprPkg::IoConi);
    isDatao = ioValid && (ioFunc == aprPkg::IoDatao);
    isDatai = ioValid && (ioFunc == aprPkg::IoDatai);
    isLoad  = ioValid && (ioFunc == aprPkg::IoLoadBlocks);
  end

  // Condition selects only act on a CONO
  always_comb begin
    ctl.selEn    = isCono & ioData[aprPkg::CoSelEn];
    ctl.selDis   = isCono & ioData[aprPkg::CoSelDis];
    ctl.selClr   = isCono & ioData[aprPkg::CoSelClr];
    ctl.selSet   = isCono & ioData[aprPkg::CoSelSet];
    ctl.condMask = ioData[aprPkg::CoMaskLsb +: aprPkg::NumConds];
    ctl.piaLoad  = isCono;
    ctl.piaLevel = ioData[aprPkg::CoPiaLsb +: 3];
  end

  always_comb begin
    ctl.loadBlocks  = isLoad;
    ctl.curBlockIn  = ioData[aprPkg::CurBlockLsb +: BlockBits];
    ctl.prevBlockIn = ioData[aprPkg::PrevBlockLsb +: BlockBits];
    ctl.dataoLoad   = isDatao;
    ctl.compIn      = ioData[aprPkg::CompLsb +: 4];
  end

  always_comb begin
    ctl.readConi  = isConi;
    ctl.readDatai = isDatai;
  end

endmodule

`default_nettype wire

// ==== design/aprPkg.sv ====
`default_nettype none

package aprPkg;

  // I/O function of a command on the device bus
  typedef enum logic [2:0] {
    IoNone,
    IoCono,
    IoConi,
    IoDatao,
    IoDatai,
    IoLoadBlocks
  } ioFuncT;

  // Fast-memory address source, in microcode FMADR order
  typedef enum logic [2:0] {
    FmAc,
    FmAcPlus1,
    FmXr,
    FmVma,
    FmAcPlus2,
    FmAcPlus3,
    FmAcMagic,
    FmMagic
  } fmSrcT;

  localparam int WordBits = 36;
  localparam int NumConds = 8;

  // Condition bit positions
  localparam int CondSbusErr    = 0;
  localparam int CondNxmErr     = 1;
  localparam int CondIoPfErr    = 2;
  localparam int CondMbParErr   = 3;
  localparam int CondCDirParErr = 4;
  localparam int CondSAdrParErr = 5;
  localparam int CondPwrFail    = 6;
  localparam int CondSweepDone  = 7;

  // CONO fields
  localparam int CoSelEn     = 35;
  localparam int CoSelDis    = 34;
  localparam int CoSelClr    = 33;
  localparam int CoSelSet    = 32;
  localparam int CoMaskLsb   = 8;
  localparam int CoPiaLsb    = 0;

  // DATAI and block-load fields
  localparam int CurBlockLsb  = 0;
  localparam int PrevBlockLsb = 3;
  localparam int CompLsb      = 6;

endpackage

`default_nettype wire

// ==== design/aprReadback.sv ====
`timescale 1ns/1ps
`default_nettype none

module aprReadback (
  input  logic                         clk,
  input  logic                         reset,
  aprCtlIf.readback                    ctl,
  input  logic [aprPkg::NumConds-1:0]  flags,
  input  logic [aprPkg::NumConds-1:0]  enables,
  input  logic                         aprInterrupt,
  input  logic [2:0]                   piaLevel,
  input  logic [2:0]                   curBlock,
  input  logic [2:0]                   prevBlock,
  output logic [aprPkg::WordBits-1:0]  rdData,
  output logic                         rdValid
);

  // Fetch, read, write, user compare bits
  logic [3:0] compBits;
  logic [aprPkg::WordBits-1:0] coniWord;
  logic [aprPkg::WordBits-1:0] dataiWord;

  always_comb begin
    coniWord  = {16'b0, piaLevel, aprInterrupt, enables, flags};
    dataiWord = {26'b0, compBits, prevBlock, curBlock};
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      compBits <= '0;
      rdValid  <= 1'b0;
    end else begin
      rdValid <= ctl.readConi | ctl.readDatai;
      if (ctl.dataoLoad) begin
        compBits <= ctl.compIn;
      end
    end
  end

  // Word holds until the next read
  always_ff @(posedge clk) begin
    if (ctl.readConi) begin
      rdData <= coniWord;
    end else if (ctl.readDatai) begin
      rdData <= dataiWord;
    end
  end

endmodule

`default_nettype wire

// ==== design/aprTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module aprTop #(
  parameter int BlockBits = 3
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         ioValid,
  input  aprPkg::ioFuncT               ioFunc,
  input  logic [aprPkg::WordBits-1:0]  ioData,
  input  logic                         sbusErr,
  input  logic                         nxmErr,
  input  logic                         ioPfErr,
  input  logic                         mbParErr,
  input  logic                         cDirParErr,
  input  logic                         sAdrParErr,
  input  logic                         pwrWarn,
  input  logic                         sweepBusy,
  input  logic [3:0]                   ac,
  input  logic [3:0]                   xr,
  input  logic [3:0]                   vmaAdr,
  input  logic [8:0]                   magic,
  input  aprPkg::fmSrcT                fmSrc,
  input  logic                         xrPrevious,
  input  logic                         vmaPrevEn,
  input  logic                         loadVmaContext,
  output logic [aprPkg::NumConds-1:0]  flags,
  output logic [aprPkg::NumConds-1:0]  enables,
  output logic [2:0]                   piaLevel,
  output logic                         aprInterrupt,
  output logic [BlockBits-1:0]         curBlock,
  output logic [BlockBits-1:0]         prevBlock,
  output logic [3:0]                   fmAdr,
  output logic [BlockBits-1:0]         fmBlock,
  output logic [aprPkg::WordBits-1:0]  rdData,
  output logic                         rdValid
);

  aprCtlIf #(.BlockBits(BlockBits)) ctl ();

  aprIoDecode #(.BlockBits(BlockBits)) i_decode (
    .ioValid (ioValid),
    .ioFunc  (ioFunc),
    .ioData  (ioData),
    .ctl     (ctl.decoder)
  );

  aprConditionFlags i_flags (
    .clk          (clk),
    .reset        (reset),
    .sbusErr      (sbusErr),
    .nxmErr       (nxmErr),
    .ioPfErr      (ioPfErr),
    .mbParErr     (mbParErr),
    .cDirParErr   (cDirParErr),
    .sAdrParErr   (sAdrParErr),
    .pwrWarn      (pwrWarn),
    .sweepBusy    (sweepBusy),
    .ctl          (ctl.flags),
    .flags        (flags),
    .enables      (enables),
    .piaLevel     (piaLevel),
    .aprInterrupt (aprInterrupt)
  );

  aprFmAddress #(.BlockBits(BlockBits)) i_fmAddress (
    .clk            (clk),
    .reset          (reset),
    .ac             (ac),
    .xr             (xr),
    .vmaAdr         (vmaAdr),
    .magic          (magic),
    .fmSrc          (fmSrc),
    .xrPrevious     (xrPrevious),
    .vmaPrevEn      (vmaPrevEn),
    .loadVmaContext (loadVmaContext),
    .ctl            (ctl.blocks),
    .curBlock       (curBlock),
    .prevBlock      (prevBlock),
    .fmAdr          (fmAdr),
    .fmBlock        (fmBlock)
  );

  aprReadback i_readback (
    .clk          (clk),
    .reset        (reset),
    .ctl          (ctl.readback),
    .flags        (flags),
    .enables      (enables),
    .aprInterrupt (aprInterrupt),
    .piaLevel     (piaLevel),
    .curBlock     (curBlock),
    .prevBlock    (prevBlock),
    .rdData       (rdData),
    .rdValid      (rdValid)
  );

endmodule

`default_nettype wire

// ==== tests/aprTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module aprTb;

  logic clk;
  logic reset;
  logic ioValid;
  aprPkg::ioFuncT ioFunc;
  logic [35:0] ioData;
  logic sbusErr;
  logic nxmErr;
  logic ioPfErr;
  logic mbParErr;
  logic cDirParErr;
  logic sAdrParErr;
  logic pwrWarn;
  logic sweepBusy;
  logic [3:0] ac;
  logic [3:0] xr;
  logic [3:0] vmaAdr;
  logic [8:0] magic;
  aprPkg::fmSrcT fmSrc;
  logic xrPrevious;
  logic vmaPrevEn;
  logic loadVmaContext;
  logic [7:0] flags;
  logic [7:0] enables;
  logic [2:0] piaLevel;
  logic aprInterrupt;
  logic [2:0] curBlock;
  logic [2:0] prevBlock;
  logic [3:0] fmAdr;
  logic [2:0] fmBlock;
  logic [35:0] rdData;
  logic rdValid;

  // Reference model state
  logic [7:0] mFlags;
  logic [7:0] mEn;
  logic [2:0] mPia;
  logic [2:0] mCur;
  logic [2:0] mPrev;
  logic [2:0] mVma;
  logic [3:0] mComp;
  logic mSweepQ;
  logic mRdValid;
  logic [35:0] mRdData;

  integer seed;
  int errors;
  int timeouts;
  string testName;

  aprTop #(.BlockBits(3)) i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic updateModel();
    logic [7:0] events;
    logic [7:0] mask;
    if (reset) begin
      mFlags = '0;
      mEn = '0;
      mPia = '0;
      mCur = '0;
      mPrev = '0;
      mVma = '0;
      mComp = '0;
      mSweepQ = 1'b0;
      mRdValid = 1'b0;
    end else begin
      events = {mSweepQ & ~sweepBusy, pwrWarn, sAdrParErr, cDirParErr,
                mbParErr, ioPfErr, nxmErr, sbusErr};
      mask = ioData[15:8];
      mRdValid = ioValid && (ioFunc == aprPkg::IoConi || ioFunc == aprPkg::IoDatai);
      // Read words capture the state before this edge
      if (ioValid && ioFunc == aprPkg::IoConi) begin
        mRdData = {16'b0, mPia, |(mFlags & mEn), mEn, mFlags};
      end else if (ioValid && ioFunc == aprPkg::IoDatai) begin
        mRdData = {26'b0, mComp, mPrev, mCur};
      end
      if (ioValid && ioFunc == aprPkg::IoCono) begin
        mFlags = events | (ioData[32] ? mask : 8'h00) | (mFlags & ~(ioData[33] ? mask : 8'h00));
        mEn = (mEn | (ioData[35] ? mask : 8'h00)) & ~(ioData[34] ? mask : 8'h00);
        mPia = ioData[2:0];
      end else begin
        mFlags = events | mFlags;
      end
      if (loadVmaContext) begin
        mVma = vmaPrevEn ? mPrev : mCur;
      end
      if (ioValid && ioFunc == aprPkg::IoLoadBlocks) begin
        mCur = ioData[2:0];
        mPrev = ioData[5:3];
      end
      if (ioValid && ioFunc == aprPkg::IoDatao) begin
        mComp = ioData[9:6];
      end
      mSweepQ = sweepBusy;
    end
  endtask

  always @(posedge clk) begin
    updateModel();
  end

  task automatic reportMismatch(input string what, input logic [35:0] expV,
                                input logic [35:0] actV);
    errors++;
    $display("ERROR %s: %s expected %h actual %h", testName, what, expV, actV);
  endtask

  task automatic checkState();
    logic [3:0] expAdr;
    logic [2:0] expBlock;
    case (fmSrc)
      aprPkg::FmAc:      expAdr = ac;
      aprPkg::FmAcPlus1: expAdr = ac + 4'd1;
      aprPkg::FmXr:      expAdr = xr;
      aprPkg::FmVma:     expAdr = vmaAdr;
      aprPkg::FmAcPlus2: expAdr = ac + 4'd2;
      aprPkg::FmAcPlus3: expAdr = ac + 4'd3;
      aprPkg::FmAcMagic: expAdr = ac + magic[8:5];
      aprPkg::FmMagic:   expAdr = magic[8:5];
    endcase
    case (fmSrc)
      aprPkg::FmXr:    expBlock = xrPrevious ? mPrev : mCur;
      aprPkg::FmVma:   expBlock = mVma;
      aprPkg::FmMagic: expBlock = magic[4:2];
      default:         expBlock = mCur;
    endcase
    if (flags !== mFlags) reportMismatch("flags", 36'(mFlags), 36'(flags));
    if (enables !== mEn) reportMismatch("enables", 36'(mEn), 36'(enables));
    if (piaLevel !== mPia) reportMismatch("piaLevel", 36'(mPia), 36'(piaLevel));
    if (aprInterrupt !== |(mFlags & mEn)) begin
      reportMismatch("aprInterrupt", 36'(|(mFlags & mEn)), 36'(aprInterrupt));
    end
    if (curBlock !== mCur) reportMismatch("curBlock", 36'(mCur), 36'(curBlock));
    if (prevBlock !== mPrev) reportMismatch("prevBlock", 36'(mPrev), 36'(prevBlock));
    if (rdValid !== mRdValid) reportMismatch("rdValid", 36'(mRdValid), 36'(rdValid));
    if (mRdValid && rdData !== mRdData) reportMismatch("rdData", mRdData, rdData);
    if (fmAdr !== expAdr) reportMismatch("fmAdr", 36'(expAdr), 36'(fmAdr));
    if (fmBlock !== expBlock) reportMismatch("fmBlock", 36'(expBlock), 36'(fmBlock));
  endtask

  task automatic nextCycle();
    @(negedge clk);
    checkState();
  endtask

  task automatic idle();
    ioValid = 1'b0;
    ioFunc = aprPkg::IoNone;
    ioData = '0;
    sbusErr = 1'b0;
    nxmErr = 1'b0;
    ioPfErr = 1'b0;
    mbParErr = 1'b0;
    cDirParErr = 1'b0;
    sAdrParErr = 1'b0;
    pwrWarn = 1'b0;
    loadVmaContext = 1'b0;
  endtask

  task automatic driveRandom();
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    logic [2:0] fn;
    r1 = $random(seed);
    r2 = $random(seed);
    r3 = $random(seed);
    fn = r2[31:29];
    ioValid = r2[28];
    // Unused codes fold onto CONO
    ioFunc = aprPkg::ioFuncT'((fn > 3'd5) ? 3'd1 : fn);
    ioData = {r3[31:28], r1};
    sbusErr = (r2[2:0] == 3'd0);
    nxmErr = (r2[5:3] == 3'd0);
    ioPfErr = (r2[8:6] == 3'd0);
    mbParErr = (r2[11:9] == 3'd0);
    cDirParErr = (r2[14:12] == 3'd0);
    sAdrParErr = (r2[17:15] == 3'd0);
    pwrWarn = (r2[20:18] == 3'd0);
    if (r2[23:21] == 3'd0) sweepBusy = ~sweepBusy;
    ac = r3[3:0];
    xr = r3[7:4];
    vmaAdr = r3[11:8];
    magic = r3[20:12];
    fmSrc = aprPkg::fmSrcT'(r3[23:21]);
    xrPrevious = r3[24];
    vmaPrevEn = r3[25];
    loadVmaContext = r3[26];
  endtask

  task automatic issueRead(input aprPkg::ioFuncT func);
    int waited;
    idle();
    ioValid = 1'b1;
    ioFunc = func;
    nextCycle();
    idle();
    waited = 0;
    while (rdValid !== 1'b1 && waited < 8) begin
      nextCycle();
      waited++;
    end
    if (rdValid !== 1'b1) begin
      timeouts++;
      $display("Read in %s got no rdValid within 8 cycles", testName);
    end
  endtask

  initial begin
    seed = 32'h546e;
    errors = 0;
    timeouts = 0;
    testName = "reset";
    reset = 1'b1;
    idle();
    sweepBusy = 1'b0;
    ac = '0;
    xr = '0;
    vmaAdr = '0;
    magic = '0;
    fmSrc = aprPkg::FmAc;
    xrPrevious = 1'b0;
    vmaPrevEn = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    testName = "randomTraffic";
    for (int i = 0; i < 300; i++) begin
      repeat (6) begin
        nextCycle();
        driveRandom();
      end
      nextCycle();
      issueRead((i % 2 == 1) ? aprPkg::IoDatai : aprPkg::IoConi);
    end

    // Clear of every flag together with an NXM event
    testName = "eventVsClear";
    nextCycle();
    idle();
    sweepBusy = 1'b0;
    nextCycle();
    ioValid = 1'b1;
    ioFunc = aprPkg::IoCono;
    ioData = 36'h2_0000_ff00;
    nxmErr = 1'b1;
    nextCycle();
    idle();
    if (flags !== 8'h02) reportMismatch("flags", 36'h2, 36'(flags));

    testName = "sweepEdge";
    sweepBusy = 1'b1;
    repeat (4) nextCycle();
    if (flags[7] !== 1'b0) reportMismatch("sweepDone", 36'h0, 36'(flags[7]));
    sweepBusy = 1'b0;
    nextCycle();
    if (flags[7] !== 1'b1) reportMismatch("sweepDone", 36'h1, 36'(flags[7]));
    issueRead(aprPkg::IoConi);

    nextCycle();
    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/aprTop_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module aprTopAssertions (
  input logic           clk,
  input logic           reset,
  input logic           ioValid,
  input aprPkg::ioFuncT ioFunc,
  input logic [7:0]     enables,
  input logic           aprInterrupt,
  input logic           rdValid
);

  logic readCmd;

  assign readCmd = ioValid && (ioFunc == aprPkg::IoConi || ioFunc == aprPkg::IoDatai);

  // Pulse only follows a read command
  rdValidFromRead: assert property (@(posedge clk) disable iff (reset)
    rdValid |-> $past(readCmd)) else $error("rdValid without a read command");

  // Ends after one cycle unless a back-to-back read was issued
  rdValidOneCycle: assert property (@(posedge clk) disable iff (reset)
    (rdValid && !readCmd) |=> !rdValid) else $error("rdValid held past one cycle");

  intLowAfterReset: assert property (@(posedge clk)
    reset |=> !aprInterrupt) else $error("aprInterrupt high after reset");

  intNeedsEnable: assert property (@(posedge clk) disable iff (reset)
    $rose(aprInterrupt) |-> (enables != 8'h00)) else $error("aprInterrupt with no enables");

endmodule

bind aprTop aprTopAssertions i_assertions (
  .clk          (clk),
  .reset        (reset),
  .ioValid      (ioValid),
  .ioFunc       (ioFunc),
  .enables      (enables),
  .aprInterrupt (aprInterrupt),
  .rdValid      (rdValid)
);

`default_nettype wire
